//--- tb.f
+incdir+verification
source/mmu_pkg.sv
source/mmu_if.sv
source/mmu_req_stage.sv
source/mmu_entry_cache.sv
source/mmu_walker.sv
source/mmu_resp_stage.sv
source/mmu_top.sv
verification/tb_mmu.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        := tb_mmu
FILELIST   := tb.f
OBJ_DIR    := obj_dir
PASS_MSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_mmu_tasks.svh
localparam logic [21:0] root_ppn = 22'h000100;
localparam logic [21:0] l0_ppn   = 22'h000101;
localparam logic [11:0] sp_ppn1  = 12'h9c3;

// pte flag bits in d a g u x w r v order
localparam logic [7:0] f_v   = 8'h01;
localparam logic [7:0] f_r   = 8'h02;
localparam logic [7:0] f_w   = 8'h04;
localparam logic [7:0] f_x   = 8'h08;
localparam logic [7:0] f_u   = 8'h10;
localparam logic [7:0] f_a   = 8'h40;
localparam logic [7:0] f_d   = 8'h80;
localparam logic [7:0] f_all = f_v | f_r | f_w | f_x | f_a | f_d;

localparam mmu_pkg::fault_t fault_none = '{bus_err: 1'b0, page_fault: 1'b0};
localparam mmu_pkg::fault_t fault_page = '{bus_err: 1'b0, page_fault: 1'b1};
localparam mmu_pkg::fault_t fault_bus  = '{bus_err: 1'b1, page_fault: 1'b0};

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
    return {ppn, 2'b00, flags};
endfunction

function automatic logic [31:0] make_va(input logic [9:0] vpn1, input logic [9:0] vpn0,
                                        input logic [11:0] off);
    return {vpn1, vpn0, off};
endfunction

// table base is ppn * 4096 and each entry is one word
function automatic logic [33:0] pte_addr(input logic [21:0] table_ppn, input logic [9:0] idx);
    return 34'(table_ppn) * 34'd4096 + 34'(idx) * 34'd4;
endfunction

function automatic logic [21:0] page_ppn(input logic [9:0] vpn0);
    return 22'h2a5000 + 22'(vpn0);
endfunction

function automatic logic [33:0] page_pa(input logic [21:0] ppn, input logic [11:0] off);
    return 34'(ppn) * 34'd4096 + 34'(off);
endfunction

// 4 MiB page keeps the low 22 bits of va
function automatic logic [33:0] super_pa(input logic [11:0] ppn1, input logic [21:0] low);
    return 34'(ppn1) * 34'h40_0000 + 34'(low);
endfunction

function automatic logic [31:0] read_word(input logic [33:0] addr);
    if (pt_mem.exists(addr)) begin
        return pt_mem[addr];
    end
    return '0;
endfunction

task automatic respond(input logic [33:0] addr);
    mem_rvalid = 1'b1;
    mem_rdata  = read_word(addr);
    mem_rerr   = err_en && (addr == err_addr);
endtask

task automatic build_tables();
    pt_mem[pte_addr(root_ppn, 10'd1)] = make_pte(l0_ppn, f_v);
    pt_mem[pte_addr(root_ppn, 10'd2)] = make_pte({sp_ppn1, 10'h000}, f_all);
    pt_mem[pte_addr(root_ppn, 10'd3)] = make_pte({sp_ppn1, 10'h005}, f_all);
    pt_mem[pte_addr(l0_ppn, 10'd0)]   = make_pte(page_ppn(10'd0), f_all);
    pt_mem[pte_addr(l0_ppn, 10'd1)]   = make_pte(page_ppn(10'd1), f_v | f_r | f_a | f_d);
    pt_mem[pte_addr(l0_ppn, 10'd2)]   = make_pte(page_ppn(10'd2), f_all | f_u);
    pt_mem[pte_addr(l0_ppn, 10'd4)]   = make_pte(page_ppn(10'd4), f_all & ~f_a);
    pt_mem[pte_addr(l0_ppn, 10'd5)]   = make_pte(page_ppn(10'd5), f_all & ~f_d);
    pt_mem[pte_addr(l0_ppn, 10'd7)]   = make_pte(page_ppn(10'd7), f_all);
endtask

task automatic check_pa(input string what, input logic [33:0] got, input logic [33:0] exp);
    if (got !== exp) begin
        $display("ERROR %0t %s: got %h expected %h", $time, what, got, exp);
        errors++;
    end
endtask

task automatic check_fault(input string what, input mmu_pkg::fault_t got,
                           input mmu_pkg::fault_t exp);
    if (got !== exp) begin
        $display("ERROR %0t %s: got %b expected %b", $time, what, got, exp);
        errors++;
    end
endtask

task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
        $display("ERROR %0t %s: got %0d expected %0d", $time, what, got, exp);
        errors++;
    end
endtask

task automatic start_test(input string name);
    cur_test = name;
    err_base = errors;
    tests_run++;
endtask

task automatic finish_test();
    if (errors == err_base) begin
        $display("test %s: ok", cur_test);
    end else begin
        $display("test %s: %0d errors", cur_test, errors - err_base);
        tests_failed++;
    end
endtask

task automatic pulse_flush();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
endtask

// negative exp_reads or exp_latency skips that check
task automatic run_check(input logic [31:0] vaddr, input mmu_pkg::access_e acc,
                         input mmu_pkg::priv_e priv, input logic sum_bit,
                         input logic [33:0] exp_pa, input mmu_pkg::fault_t exp_fault,
                         input int exp_reads, input int exp_latency);
    int start;
    int latency;
    start    = read_log.size();
    va       = vaddr;
    access   = acc;
    prv      = priv;
    sum      = sum_bit;
    va_valid = 1'b1;
    @(negedge clk);
    va_valid = 1'b0;
    latency  = 1;
    while (!pa_valid && latency < wait_limit) begin
        @(negedge clk);
        latency++;
    end
    if (!pa_valid) begin
        $display("no pa_valid within %0d cycles for va %h at %0t", wait_limit, vaddr, $time);
        errors++;
    end else begin
        check_fault("pa_bad", pa_bad, exp_fault);
        if (exp_fault == fault_none) begin
            check_pa("pa", pa, exp_pa);
        end
        if (exp_reads >= 0) begin
            check_count("reads", read_log.size() - start, exp_reads);
        end
        if (exp_latency >= 0) begin
            check_count("pa_valid latency", latency, exp_latency);
        end
    end
endtask

task automatic bare_passthrough();
    start_test("bare passthrough");
    satp_mode = 1'b0;
    run_check(32'hdead_beef, mmu_pkg::acc_load, mmu_pkg::priv_s, 1'b0,
              34'hdead_beef, fault_none, 0, 1);
    satp_mode = 1'b1;
    run_check(32'h8040_1234, mmu_pkg::acc_store, mmu_pkg::priv_m, 1'b0,
              34'h8040_1234, fault_none, 0, 1);
    // fetch ignores mprv, so machine mode stays bare
    mprv = 1'b1;
    mpp  = mmu_pkg::priv_s;
    run_check(32'hffff_f000, mmu_pkg::acc_fetch, mmu_pkg::priv_m, 1'b0,
              34'hffff_f000, fault_none, 0, 1);
    mprv = 1'b0;
    finish_test();
endtask

task automatic walk_4k_page();
    logic [31:0] v;
    int          base;
    start_test("4k walk");
    satp_mode = 1'b1;
    v    = make_va(10'd1, 10'd0, 12'h5a4);
    base = read_log.size();
    run_check(v, mmu_pkg::acc_load, mmu_pkg::priv_s, 1'b0,
              page_pa(page_ppn(10'd0), 12'h5a4), fault_none, 2, -1);
    check_pa("mem_addr", read_log[base], pte_addr(root_ppn, 10'd1));
    check_pa("mem_addr", read_log[base + 1], pte_addr(l0_ppn, 10'd0));
    // machine load under mprv walks as supervisor
    mprv = 1'b1;
    mpp  = mmu_pkg::priv_s;
    v    = make_va(10'd1, 10'd5, 12'h010);
    run_check(v, mmu_pkg::acc_load, mmu_pkg::priv_m, 1'b0,
              page_pa(page_ppn(10'd5), 12'h010), fault_none, 2, -1);
    mprv = 1'b0;
    finish_test();
endtask

task automatic superpages();
    logic [31:0] v;
    int          base;
    start_test("superpage");
    v    = make_va(10'd2, 10'h155, 12'h0c8);
    base = read_log.size();
    run_check(v, mmu_pkg::acc_fetch, mmu_pkg::priv_s, 1'b0,
              super_pa(sp_ppn1, v[21:0]), fault_none, 1, -1);
    check_pa("mem_addr", read_log[base], pte_addr(root_ppn, 10'd2));
    // another 4k piece of the same superpage hits
    v = make_va(10'd2, 10'h2f0, 12'h7ff);
    run_check(v, mmu_pkg::acc_load, mmu_pkg::priv_s, 1'b0,
              super_pa(sp_ppn1, v[21:0]), fault_none, 0, 1);
    v = make_va(10'd3, 10'h0aa, 12'h010);
    run_check(v, mmu_pkg::acc_load, mmu_pkg::priv_s, 1'b0, 34'h0, fault_page, 1, -1);
    finish_test();
endtask

task automatic permission_faults();
    start_test("permission faults");
    run_check(make_va(10'd1, 10'd1, 12'h100), mmu_pkg::acc_store, mmu_pkg::priv_s, 1'b0,
              34'h0, fault_page, -1, -1);
    run_check(make_va(10'd1, 10'd1, 12'h104), mmu_pkg::acc_fetch, mmu_pkg::priv_s, 1'b0,
              34'h0, fault_page, -1, -1);
    run_check(make_va(10'd1, 10'd2, 12'h200), mmu_pkg::acc_load, mmu_pkg::priv_s, 1'b0,
              34'h0, fault_page, -1, -1);
    // sum lets supervisor load from a user page
    run_check(make_va(10'd1, 10'd2, 12'h204), mmu_pkg::acc_load, mmu_pkg::priv_s, 1'b1,
              page_pa(page_ppn(10'd2), 12'h204), fault_none, -1, -1);
    run_check(make_va(10'd1, 10'd2, 12'h208), mmu_pkg::acc_fetch, mmu_pkg::priv_s, 1'b1,
              34'h0, fault_page, -1, -1);
    run_check(make_va(10'd1, 10'd0, 12'h300), mmu_pkg::acc_load, mmu_pkg::priv_u, 1'b0,
              34'h0, fault_page, -1, -1);
    run_check(make_va(10'd1, 10'd4, 12'h400), mmu_pkg::acc_load, mmu_pkg::priv_s, 1'b0,
              34'h0, fault_page, -1, -1);
    run_check(make_va(10'd1, 10'd5, 12'h500), mmu_pkg::acc_store, mmu_pkg::priv_s, 1'b0,
              34'h0, fault_page, -1, -1);
    finish_test();
endtask

task automatic cache_and_flush();
    logic [31:0] v;
    logic [11:0] off;
    int          i;
    start_test("cache and flush");
    pulse_flush();
    v = make_va(10'd1, 10'd1, 12'h000);
    run_check(v, mmu_pkg::acc_load, mmu_pkg::priv_s, 1'b0,
              page_pa(page_ppn(10'd1), 12'h000), fault_none, 2, -1);
    for (i = 0; i < 4; i++) begin
        ofs_rng = xorshift32(ofs_rng);
        off     = ofs_rng[11:0];
        v       = make_va(10'd1, 10'd1, off);
        run_check(v, mmu_pkg::acc_load, mmu_pkg::priv_s, 1'b0,
                  page_pa(page_ppn(10'd1), off), fault_none, 0, 1);
    end
    // cached read-only page still refuses a store
    run_check(v, mmu_pkg::acc_store, mmu_pkg::priv_s, 1'b0, 34'h0, fault_page, 0, 1);
    pulse_flush();
    run_check(v, mmu_pkg::acc_load, mmu_pkg::priv_s, 1'b0,
              page_pa(page_ppn(10'd1), off), fault_none, 2, -1);
    finish_test();
endtask

task automatic bus_error_walk();
    logic [31:0] v;
    start_test("bus error");
    err_addr = pte_addr(l0_ppn, 10'd7);
    err_en   = 1'b1;
    v        = make_va(10'd1, 10'd7, 12'h3c0);
    run_check(v, mmu_pkg::acc_load, mmu_pkg::priv_s, 1'b0, 34'h0, fault_bus, 2, -1);
    err_en = 1'b0;
    // failed walk left nothing behind
    run_check(v, mmu_pkg::acc_load, mmu_pkg::priv_s, 1'b0,
              page_pa(page_ppn(10'd7), 12'h3c0), fault_none, 2, -1);
    finish_test();
endtask

//--- verification/tb_mmu.sv
`timescale 1ns/1ps

module tb_mmu;

    localparam int cycle_limit = 3000;
    localparam int wait_limit  = 60;

    logic                          clk = 1'b0;
    logic                          rstn;
    logic                          va_valid;
    logic [mmu_pkg::va_w-1:0]      va;
    mmu_pkg::access_e              access;
    mmu_pkg::priv_e                prv;
    logic                          mprv;
    mmu_pkg::priv_e                mpp;
    logic                          sum;
    logic                          satp_mode;
    logic [mmu_pkg::ppn_w-1:0]     satp_ppn;
    logic                          flush;
    logic                          mem_req;
    logic                          mem_gnt = 1'b0;
    logic [mmu_pkg::pa_w-1:0]      mem_addr;
    logic                          mem_rvalid = 1'b0;
    logic [mmu_pkg::pte_w-1:0]     mem_rdata = '0;
    logic                          mem_rerr = 1'b0;
    logic                          pa_valid;
    logic [mmu_pkg::pa_w-1:0]      pa;
    mmu_pkg::fault_t               pa_bad;

    // sparse page table words keyed by byte address
    logic [mmu_pkg::pte_w-1:0]     pt_mem [logic [mmu_pkg::pa_w-1:0]];
    logic [mmu_pkg::pa_w-1:0]      read_log [$];
    logic [mmu_pkg::pa_w-1:0]      err_addr;
    logic                          err_en;
    logic [31:0]                   mem_rng = 32'h58ae;
    logic [31:0]                   ofs_rng;
    int                            cycle_cnt = 0;
    int                            errors;
    int                            err_base;
    int                            tests_run;
    int                            tests_failed;
    string                         cur_test;

    `include "tb_mmu_tasks.svh"

    mmu_top i_dut (
        .clk        (clk),
        .rstn       (rstn),
        .va_valid   (va_valid),
        .va         (va),
        .access     (access),
        .prv        (prv),
        .mprv       (mprv),
        .mpp        (mpp),
        .sum        (sum),
        .satp_mode  (satp_mode),
        .satp_ppn   (satp_ppn),
        .flush      (flush),
        .mem_req    (mem_req),
        .mem_gnt    (mem_gnt),
        .mem_addr   (mem_addr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .mem_rerr   (mem_rerr),
        .pa_valid   (pa_valid),
        .pa         (pa),
        .pa_bad     (pa_bad)
    );

    always #5 clk = ~clk;

    // 25 translations of up to 60 cycles each and the reset stay well under this
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("run stopped after %0d cycles, the tests did not finish", cycle_cnt);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // grant delay and response latency of 0 to 3 cycles each
    always begin : mem_model
        int                       gnt_wait;
        int                       rsp_wait;
        logic [mmu_pkg::pa_w-1:0] addr;
        @(negedge clk);
        if (rstn && mem_req) begin
            mem_rng  = xorshift32(mem_rng);
            gnt_wait = int'(mem_rng[1:0]);
            mem_rng  = xorshift32(mem_rng);
            rsp_wait = int'(mem_rng[1:0]);
            repeat (gnt_wait) @(negedge clk);
            addr = mem_addr;
            read_log.push_back(addr);
            mem_gnt = 1'b1;
            if (rsp_wait == 0) begin
                respond(addr);
            end
            @(negedge clk);
            mem_gnt = 1'b0;
            if (rsp_wait != 0) begin
                mem_rvalid = 1'b0;
                repeat (rsp_wait - 1) @(negedge clk);
                respond(addr);
                @(negedge clk);
            end
            mem_rvalid = 1'b0;
            mem_rerr   = 1'b0;
        end
    end

    initial begin
        rstn         = 1'b0;
        va_valid     = 1'b0;
        va           = '0;
        access       = mmu_pkg::acc_load;
        prv          = mmu_pkg::priv_s;
        mprv         = 1'b0;
        mpp          = mmu_pkg::priv_u;
        sum          = 1'b0;
        satp_mode    = 1'b0;
        satp_ppn     = root_ppn;
        flush        = 1'b0;
        err_en       = 1'b0;
        err_addr     = '0;
        ofs_rng      = 32'h58ae;
        errors       = 0;
        err_base     = 0;
        tests_run    = 0;
        tests_failed = 0;
        build_tables();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        bare_passthrough();
        walk_4k_page();
        superpages();
        permission_faults();
        cache_and_flush();
        bus_error_walk();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- source/mmu_top.sv
`timescale 1ns/1ps

module mmu_top (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        va_valid,
    input  logic [mmu_pkg::va_w-1:0]    va,
    input  mmu_pkg::access_e            access,
    input  mmu_pkg::priv_e              prv,
    input  logic                        mprv,
    input  mmu_pkg::priv_e              mpp,
    input  logic                        sum,
    input  logic                        satp_mode,
    input  logic [mmu_pkg::ppn_w-1:0]   satp_ppn,
    input  logic                        flush,
    output logic                        mem_req,
    input  logic                        mem_gnt,
    output logic [mmu_pkg::pa_w-1:0]    mem_addr,
    input  logic                        mem_rvalid,
    input  logic [mmu_pkg::pte_w-1:0]   mem_rdata,
    input  logic                        mem_rerr,
    output logic                        pa_valid,
    output logic [mmu_pkg::pa_w-1:0]    pa,
    output mmu_pkg::fault_t             pa_bad
);

    logic [2*mmu_pkg::vpn_w-1:0] lookup_vpn;
    mmu_pkg::priv_e              eff_priv;
    logic                        cache_hit;
    logic [mmu_pkg::ppn_w-1:0]   cache_pa;
    mmu_pkg::fault_t             cache_fault;

    mmu_req_if    req_if ();
    mmu_fill_if   fill_if ();
    mmu_result_if fast_if ();
    mmu_result_if walk_if ();

    mmu_req_stage u_req_stage (
        .clk         (clk),
        .rstn        (rstn),
        .va_valid    (va_valid),
        .va          (va),
        .access      (access),
        .prv         (prv),
        .mprv        (mprv),
        .mpp         (mpp),
        .sum         (sum),
        .satp_mode   (satp_mode),
        .cache_hit   (cache_hit),
        .cache_pa    (cache_pa),
        .cache_fault (cache_fault),
        .lookup_vpn  (lookup_vpn),
        .eff_priv    (eff_priv),
        .req         (req_if.master),
        .fast        (fast_if.master)
    );

    mmu_entry_cache u_entry_cache (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .lookup_vpn (lookup_vpn),
        .access     (access),
        .eff_priv   (eff_priv),
        .sum        (sum),
        .fill       (fill_if.slave),
        .hit        (cache_hit),
        .pa         (cache_pa),
        .fault      (cache_fault)
    );

    mmu_walker u_walker (
        .clk        (clk),
        .rstn       (rstn),
        .satp_ppn   (satp_ppn),
        .req        (req_if.slave),
        .fill       (fill_if.master),
        .res        (walk_if.master),
        .mem_req    (mem_req),
        .mem_gnt    (mem_gnt),
        .mem_addr   (mem_addr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .mem_rerr   (mem_rerr)
    );

    mmu_resp_stage u_resp_stage (
        .clk      (clk),
        .rstn     (rstn),
        .fast     (fast_if.slave),
        .walk     (walk_if.slave),
        .pa_valid (pa_valid),
        .pa       (pa),
        .pa_bad   (pa_bad)
    );

endmodule

//--- source/mmu_resp_stage.sv
`timescale 1ns/1ps

module mmu_resp_stage (
    input  logic                       clk,
    input  logic                       rstn,
    mmu_result_if.slave                fast,
    mmu_result_if.slave                walk,
    output logic                       pa_valid,
    output logic [mmu_pkg::pa_w-1:0]   pa,
    output mmu_pkg::fault_t            pa_bad
);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pa_valid <= 1'b0;
        end else begin
            pa_valid <= fast.done || walk.done;
        end
    end

    // both sources never strobe together
    always_ff @(posedge clk) begin
        if (fast.done) begin
            pa     <= fast.pa;
            pa_bad <= fast.fault;
        end else if (walk.done) begin
            pa     <= walk.pa;
            pa_bad <= walk.fault;
        end
    end

endmodule

//--- source/mmu_walker.sv
`timescale 1ns/1ps

module mmu_walker (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [mmu_pkg::ppn_w-1:0]   satp_ppn,
    mmu_req_if.slave                    req,
    mmu_fill_if.master                  fill,
    mmu_result_if.master                res,
    output logic                        mem_req,
    input  logic                        mem_gnt,
    output logic [mmu_pkg::pa_w-1:0]    mem_addr,
    input  logic                        mem_rvalid,
    input  logic [mmu_pkg::pte_w-1:0]   mem_rdata,
    input  logic                        mem_rerr
);

    mmu_pkg::walk_state_e             state;
    logic                             level;
    logic                             gnt_done;
    logic                             err_q;
    logic [mmu_pkg::ppn_w-1:0]        ppn_q;
    mmu_pkg::pte_t                    pte_q;
    mmu_pkg::fault_t                  perm;
    logic                             leaf;
    logic                             misaligned;
    logic                             pf;
    logic                             finish;
    logic                             descend;

    assign leaf       = pte_q.v && (pte_q.r || pte_q.x);
    // 4 MiB page needs ppn0 clear
    assign misaligned = level && (pte_q.ppn0 != '0);
    assign perm       = mmu_pkg::check_perm(pte_q, req.access, req.priv, req.sum);
    assign pf         = !pte_q.v || (pte_q.w && !pte_q.r) || (!leaf && !level) ||
                        (leaf && (misaligned || perm.page_fault));

    assign finish  = (state == mmu_pkg::walk_pte_check) && (err_q || leaf || pf);
    assign descend = (state == mmu_pkg::walk_pte_check) && !err_q && !leaf && !pf;

    assign mem_req  = (state == mmu_pkg::walk_mem_req) && !gnt_done;
    assign mem_addr = {ppn_q, level ? req.vpn1 : req.vpn0, 2'b00};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= mmu_pkg::walk_idle;
            level    <= 1'b1;
            gnt_done <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            case (state)
                mmu_pkg::walk_idle: begin
                    if (req.start) begin
                        level <= 1'b1;
                        state <= mmu_pkg::walk_mem_req;
                    end
                end
                mmu_pkg::walk_mem_req: begin
                    if (mem_req && mem_gnt) begin
                        gnt_done <= 1'b1;
                    end
                    // response may come with the grant
                    if (mem_rvalid) begin
                        gnt_done <= 1'b0;
                        err_q    <= mem_rerr;
                        state    <= mmu_pkg::walk_pte_check;
                    end
                end
                mmu_pkg::walk_pte_check: begin
                    if (descend) begin
                        level <= 1'b0;
                        state <= mmu_pkg::walk_mem_req;
                    end else begin
                        state <= mmu_pkg::walk_idle;
                    end
                end
                default: state <= mmu_pkg::walk_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mmu_pkg::walk_idle && req.start) begin
            ppn_q <= satp_ppn;
        end else if (descend) begin
            ppn_q <= {pte_q.ppn1, pte_q.ppn0};
        end
        if (state == mmu_pkg::walk_mem_req && mem_rvalid) begin
            pte_q <= mmu_pkg::pte_t'(mem_rdata);
        end
    end

    assign res.done             = finish;
    assign res.pa               = {pte_q.ppn1, level ? req.vpn0 : pte_q.ppn0, req.offset};
    assign res.fault.bus_err    = err_q;
    assign res.fault.page_fault = pf && !err_q;

    assign fill.fill      = finish && !err_q && !pf;
    assign fill.vpn1      = req.vpn1;
    assign fill.vpn0      = req.vpn0;
    assign fill.superpage = level;
    assign fill.pte       = pte_q;

endmodule

//--- source/mmu_entry_cache.sv
`timescale 1ns/1ps

module mmu_entry_cache (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         flush,
    input  logic [2*mmu_pkg::vpn_w-1:0]  lookup_vpn,
    input  mmu_pkg::access_e             access,
    input  mmu_pkg::priv_e               eff_priv,
    input  logic                         sum,
    mmu_fill_if.slave                    fill,
    output logic                         hit,
    output logic [mmu_pkg::ppn_w-1:0]    pa,
    output mmu_pkg::fault_t              fault
);

    logic                      valid;
    logic [mmu_pkg::vpn_w-1:0] vpn1_q;
    logic [mmu_pkg::vpn_w-1:0] vpn0_q;
    logic                      spage_q;
    mmu_pkg::pte_t             pte_q;
    logic [mmu_pkg::vpn_w-1:0] in_vpn1;
    logic [mmu_pkg::vpn_w-1:0] in_vpn0;

    assign in_vpn1 = lookup_vpn[2*mmu_pkg::vpn_w-1:mmu_pkg::vpn_w];
    assign in_vpn0 = lookup_vpn[mmu_pkg::vpn_w-1:0];

    // flush wins over a fill in the same cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (fill.fill) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill.fill) begin
            vpn1_q  <= fill.vpn1;
            vpn0_q  <= fill.vpn0;
            spage_q <= fill.superpage;
            pte_q   <= fill.pte;
        end
    end

    // superpage covers all of vpn0
    assign hit   = valid && (in_vpn1 == vpn1_q) && (spage_q || in_vpn0 == vpn0_q);
    assign pa    = {pte_q.ppn1, spage_q ? in_vpn0 : pte_q.ppn0};
    // access type may differ from the one that filled the entry
    assign fault = mmu_pkg::check_perm(pte_q, access, eff_priv, sum);

endmodule

//--- source/mmu_req_stage.sv
`timescale 1ns/1ps

module mmu_req_stage (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           va_valid,
    input  logic [mmu_pkg::va_w-1:0]       va,
    input  mmu_pkg::access_e               access,
    input  mmu_pkg::priv_e                 prv,
    input  logic                           mprv,
    input  mmu_pkg::priv_e                 mpp,
    input  logic                           sum,
    input  logic                           satp_mode,
    input  logic                           cache_hit,
    input  logic [mmu_pkg::ppn_w-1:0]      cache_pa,
    input  mmu_pkg::fault_t                cache_fault,
    output logic [2*mmu_pkg::vpn_w-1:0]    lookup_vpn,
    output mmu_pkg::priv_e                 eff_priv,
    mmu_req_if.master                      req,
    mmu_result_if.master                   fast
);

    logic                     xlate_en;
    logic [mmu_pkg::va_w-1:0] va_q;

    // mprv applies to loads and stores only
    assign eff_priv   = (access != mmu_pkg::acc_fetch && mprv) ? mpp : prv;
    assign xlate_en   = (eff_priv != mmu_pkg::priv_m) && satp_mode;
    assign lookup_vpn = va[mmu_pkg::va_w-1:mmu_pkg::page_off_w];

    // bare passthrough or cached translation
    assign fast.done  = va_valid && (!xlate_en || cache_hit);
    assign fast.pa    = xlate_en ? {cache_pa, va[mmu_pkg::page_off_w-1:0]}
                                 : {{(mmu_pkg::pa_w-mmu_pkg::va_w){1'b0}}, va};
    assign fast.fault = xlate_en ? cache_fault : '0;

    assign req.start  = va_valid && xlate_en && !cache_hit;

    // operands held for the walker until the result is out
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req.access <= mmu_pkg::acc_load;
            req.priv   <= mmu_pkg::priv_u;
            req.sum    <= 1'b0;
        end else if (va_valid) begin
            req.access <= access;
            req.priv   <= eff_priv;
            req.sum    <= sum;
        end
    end

    always_ff @(posedge clk) begin
        if (va_valid) begin
            va_q <= va;
        end
    end

    assign req.vpn1   = va_q[mmu_pkg::page_off_w+mmu_pkg::vpn_w +: mmu_pkg::vpn_w];
    assign req.vpn0   = va_q[mmu_pkg::page_off_w +: mmu_pkg::vpn_w];
    assign req.offset = va_q[mmu_pkg::page_off_w-1:0];

endmodule

//--- source/mmu_if.sv
`timescale 1ns/1ps

// request handed from the input side to the walker
interface mmu_req_if;
    logic                              start;
    logic [mmu_pkg::vpn_w-1:0]         vpn1;
    logic [mmu_pkg::vpn_w-1:0]         vpn0;
    logic [mmu_pkg::page_off_w-1:0]    offset;
    mmu_pkg::access_e                  access;
    mmu_pkg::priv_e                    priv;
    logic                              sum;

    modport master (output start, vpn1, vpn0, offset, access, priv, sum);
    modport slave  (input  start, vpn1, vpn0, offset, access, priv, sum);
endinterface

// walker writes a finished leaf into the entry cache
interface mmu_fill_if;
    logic                      fill;
    logic [mmu_pkg::vpn_w-1:0] vpn1;
    logic [mmu_pkg::vpn_w-1:0] vpn0;
    logic                      superpage;
    mmu_pkg::pte_t             pte;

    modport master (output fill, vpn1, vpn0, superpage, pte);
    modport slave  (input  fill, vpn1, vpn0, superpage, pte);
endinterface

interface mmu_result_if;
    logic                     done;
    logic [mmu_pkg::pa_w-1:0] pa;
    mmu_pkg::fault_t          fault;

    modport master (output done, pa, fault);
    modport slave  (input  done, pa, fault);
endinterface

//--- source/mmu_pkg.sv
package mmu_pkg;

    localparam int va_w       = 32;
    localparam int pa_w       = 34;
    localparam int ppn_w      = 22;
    localparam int vpn_w      = 10;
    localparam int page_off_w = 12;
    localparam int pte_w      = 32;

    typedef enum logic [1:0] {
        acc_load  = 2'b00,
        acc_store = 2'b01,
        acc_fetch = 2'b10
    } access_e;

    // same encoding as mstatus.mpp
    typedef enum logic [1:0] {
        priv_u = 2'b00,
        priv_s = 2'b01,
        priv_m = 2'b11
    } priv_e;

    typedef enum logic [1:0] {
        walk_idle      = 2'b00,
        walk_mem_req   = 2'b01,
        walk_pte_check = 2'b10
    } walk_state_e;

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    typedef struct packed {
        logic bus_err;
        logic page_fault;
    } fault_t;

    // leaf permission check without mxr
    function automatic fault_t check_perm(pte_t pte, access_e access, priv_e priv, logic sum);
        fault_t f;
        f.bus_err    = 1'b0;
        f.page_fault = (access == acc_fetch && !pte.x) ||
                       (access == acc_load  && !pte.r) ||
                       (access == acc_store && !pte.w) ||
                       (priv == priv_u && !pte.u) ||
                       (priv == priv_s && pte.u && (!sum || access == acc_fetch)) ||
                       (access == acc_store && !pte.d) ||
                       !pte.a;
        return f;
    endfunction

endpackage
